// ==== include/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////
// Core sizing
////////////////////////////////////////

// Register and memory word width
`define CPU_DATA_WIDTH 32

// Architectural registers, r0 reads as zero
`define CPU_REG_COUNT 32

// Memory depths in words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

`endif

// ==== design/cpuPkg.sv ====
`include "cpu_config.svh"

package cpuPkg;

    typedef logic [`CPU_DATA_WIDTH-1:0] dataWord;
    typedef logic [31:0] instrWord;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIndex;
    // Word address, shared by both memories
    typedef logic [$clog2(`CPU_IMEM_DEPTH)-1:0] memAddr;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Opcode field, bits 31..26; unknown codes decode as NOP
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_LW,
        OP_SW
    } opCode;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } aluOp;

    // Operand source for execute
    typedef enum logic [1:0] {
        REGFILE  = 2'b00,
        FROM_WB  = 2'b01,
        FROM_MA  = 2'b10,
        FROM_VWB = 2'b11
    } fwdSel;

endpackage

// ==== design/fetchStage.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetchStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             progWe,
    input  cpuPkg::memAddr   progAddr,
    input  cpuPkg::instrWord progData,
    input  logic             stall,
    output cpuPkg::instrWord ifInstr
);

    localparam int ADDR_BITS = $bits(cpuPkg::memAddr);

    cpuPkg::instrWord   imem [`CPU_IMEM_DEPTH];
    cpuPkg::memAddr     pc;
    logic [ADDR_BITS:0] progEnd;
    cpuPkg::instrWord   fetched;

    // Program load port, only open while the core is held in reset.
    // The last strobe marks the end of the program
    always_ff @(posedge clk) begin
        if (rst && progWe) begin
            imem[progAddr] <= progData;
            progEnd        <= {1'b0, progAddr} + 1'b1;
        end
    end

    // Words past the loaded program fetch as NOP
    assign fetched = ({1'b0, pc} < progEnd) ? imem[pc] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    ////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ifInstr <= '0;
        end else if (!stall) begin
            ifInstr <= fetched;
        end
    end

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module decodeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  cpuPkg::instrWord ifInstr,
    input  logic             wbEnable,
    input  cpuPkg::regIndex  wbRdst,
    input  cpuPkg::dataWord  wbData,
    output logic             idRegWe,
    output logic             idMemRead,
    output logic             idMemWrite,
    output logic             idRs1Needed,
    output logic             idRs2Needed,
    output logic             idUseImm,
    output cpuPkg::regIndex  idRs1,
    output cpuPkg::regIndex  idRs2,
    output cpuPkg::regIndex  idRd,
    output cpuPkg::aluOp     idAluOp,
    output cpuPkg::dataWord  idRs1Value,
    output cpuPkg::dataWord  idRs2Value,
    output cpuPkg::dataWord  idImm
);

    cpuPkg::dataWord regFile [`CPU_REG_COUNT];

    cpuPkg::regIndex rs1;
    cpuPkg::regIndex rs2;
    cpuPkg::regIndex rd;
    cpuPkg::dataWord imm;
    cpuPkg::regIndex srcA;
    cpuPkg::regIndex srcB;
    cpuPkg::dataWord readA;
    cpuPkg::dataWord readB;

    logic         dRegWe;
    logic         dMemRead;
    logic         dMemWrite;
    logic         dRs1Needed;
    logic         dRs2Needed;
    logic         dUseImm;
    cpuPkg::aluOp dAluOp;

    assign rd  = ifInstr[25:21];
    assign rs1 = ifInstr[20:16];
    assign rs2 = ifInstr[15:11];
    assign imm = {{(`CPU_DATA_WIDTH-16){ifInstr[15]}}, ifInstr[15:0]};

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////

    always_comb begin
        dRegWe     = 1'b0;
        dMemRead   = 1'b0;
        dMemWrite  = 1'b0;
        dRs1Needed = 1'b0;
        dRs2Needed = 1'b0;
        dUseImm    = 1'b0;
        dAluOp     = cpuPkg::ALU_PASS;
        case (cpuPkg::opCode'(ifInstr[31:26]))
            cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND,
            cpuPkg::OP_OR, cpuPkg::OP_XOR: begin
                dRegWe     = 1'b1;
                dRs1Needed = 1'b1;
                dRs2Needed = 1'b1;
                case (cpuPkg::opCode'(ifInstr[31:26]))
                    cpuPkg::OP_SUB: dAluOp = cpuPkg::ALU_SUB;
                    cpuPkg::OP_AND: dAluOp = cpuPkg::ALU_AND;
                    cpuPkg::OP_OR:  dAluOp = cpuPkg::ALU_OR;
                    cpuPkg::OP_XOR: dAluOp = cpuPkg::ALU_XOR;
                    default:        dAluOp = cpuPkg::ALU_ADD;
                endcase
            end
            cpuPkg::OP_ADDI: begin
                dRegWe     = 1'b1;
                dRs1Needed = 1'b1;
                dUseImm    = 1'b1;
                dAluOp     = cpuPkg::ALU_ADD;
            end
            // Address is rs1 + imm for both memory ops
            cpuPkg::OP_LW: begin
                dRegWe     = 1'b1;
                dMemRead   = 1'b1;
                dRs1Needed = 1'b1;
                dUseImm    = 1'b1;
                dAluOp     = cpuPkg::ALU_ADD;
            end
            cpuPkg::OP_SW: begin
                dMemWrite  = 1'b1;
                dRs1Needed = 1'b1;
                dRs2Needed = 1'b1;
                dUseImm    = 1'b1;
                dAluOp     = cpuPkg::ALU_ADD;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wbEnable) begin
            regFile[wbRdst] <= wbData;
        end
    end

    // A held instruction re-reads its operands, so a write retiring
    // during the stall still reaches it
    assign srcA  = stall ? idRs1 : rs1;
    assign srcB  = stall ? idRs2 : rs2;
    assign readA = (srcA == '0) ? '0 : regFile[srcA];
    assign readB = (srcB == '0) ? '0 : regFile[srcB];

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            idRegWe     <= 1'b0;
            idMemRead   <= 1'b0;
            idMemWrite  <= 1'b0;
            idRs1Needed <= 1'b0;
            idRs2Needed <= 1'b0;
            idUseImm    <= 1'b0;
            idAluOp     <= cpuPkg::ALU_PASS;
        end else if (!stall) begin
            // No write ever targets r0
            idRegWe     <= dRegWe && (rd != '0);
            idMemRead   <= dMemRead;
            idMemWrite  <= dMemWrite;
            idRs1Needed <= dRs1Needed;
            idRs2Needed <= dRs2Needed;
            idUseImm    <= dUseImm;
            idAluOp     <= dAluOp;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            idRs1 <= rs1;
            idRs2 <= rs2;
            idRd  <= rd;
            idImm <= imm;
        end
        idRs1Value <= readA;
        idRs2Value <= readB;
    end

endmodule

// ==== design/forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit (
    input  logic            idRegWe,
    input  logic            idMemRead,
    input  logic            idMemWrite,
    input  logic            idRs1Needed,
    input  logic            idRs2Needed,
    input  cpuPkg::regIndex idRs1,
    input  cpuPkg::regIndex idRs2,
    input  logic            maRegWe,
    input  logic            maMemRead,
    input  logic            maMemWrite,
    input  cpuPkg::regIndex maRs2,
    input  cpuPkg::regIndex maRd,
    input  logic            wbEnable,
    input  logic            wbIsLoad,
    input  cpuPkg::regIndex wbRdst,
    input  logic            vwbEnable,
    input  cpuPkg::regIndex vwbRdst,
    output cpuPkg::fwdSel   op1Sel,
    output cpuPkg::fwdSel   op2Sel,
    output logic            storeDataSel,
    output logic            stall
);

    logic maForward;
    logic loadInMa;
    logic rs1Hit;
    logic rs2Hit;
    logic pureStore;

    // Load data is not ready in EX/MA, only ALU results are
    assign maForward = maRegWe && !maMemRead;

    // Newest producer wins: MA, then WB, then virtual WB
    function automatic cpuPkg::fwdSel pickSource(input logic needed,
                                                 input cpuPkg::regIndex rs);
        if (!needed) begin
            return cpuPkg::REGFILE;
        end
        if (maForward && (maRd == rs)) begin
            return cpuPkg::FROM_MA;
        end
        if (wbEnable && (wbRdst == rs)) begin
            return cpuPkg::FROM_WB;
        end
        if (vwbEnable && (vwbRdst == rs)) begin
            return cpuPkg::FROM_VWB;
        end
        return cpuPkg::REGFILE;
    endfunction

    always_comb begin
        op1Sel = pickSource(idRs1Needed, idRs1);
        op2Sel = pickSource(idRs2Needed, idRs2);
    end

    ////////////////////////////////////////
    // Memory stage store data
    ////////////////////////////////////////

    // Store right behind a load of its data register
    assign storeDataSel = maMemWrite && wbEnable && wbIsLoad && (wbRdst == maRs2);

    ////////////////////////////////////////
    // Load-use stall
    ////////////////////////////////////////

    assign loadInMa  = maRegWe && maMemRead;
    assign rs1Hit    = idRs1Needed && (idRs1 == maRd);
    assign rs2Hit    = idRs2Needed && (idRs2 == maRd);
    // Writes memory and nothing else
    assign pureStore = idMemWrite && !idMemRead && !idRegWe;

    // Store data alone is covered later by storeDataSel
    assign stall = loadInMa && (rs1Hit || (rs2Hit && !pureStore));

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            idRegWe,
    input  logic            idMemRead,
    input  logic            idMemWrite,
    input  logic            idUseImm,
    input  cpuPkg::regIndex idRs2,
    input  cpuPkg::regIndex idRd,
    input  cpuPkg::aluOp    idAluOp,
    input  cpuPkg::dataWord idRs1Value,
    input  cpuPkg::dataWord idRs2Value,
    input  cpuPkg::dataWord idImm,
    input  cpuPkg::fwdSel   op1Sel,
    input  cpuPkg::fwdSel   op2Sel,
    input  cpuPkg::dataWord maResult,
    input  cpuPkg::dataWord wbData,
    input  cpuPkg::dataWord vwbData,
    output logic            maRegWe,
    output logic            maMemRead,
    output logic            maMemWrite,
    output cpuPkg::regIndex maRs2,
    output cpuPkg::regIndex maRd,
    output cpuPkg::dataWord maAluResult,
    output cpuPkg::dataWord maStoreData
);

    cpuPkg::dataWord rs1Fwd;
    cpuPkg::dataWord rs2Fwd;
    cpuPkg::dataWord opB;
    cpuPkg::dataWord aluOut;

    function automatic cpuPkg::dataWord forwardValue(input cpuPkg::fwdSel sel,
                                                     input cpuPkg::dataWord regValue);
        case (sel)
            cpuPkg::FROM_MA:  return maResult;
            cpuPkg::FROM_WB:  return wbData;
            cpuPkg::FROM_VWB: return vwbData;
            default:          return regValue;
        endcase
    endfunction

    always_comb begin
        rs1Fwd = forwardValue(op1Sel, idRs1Value);
        rs2Fwd = forwardValue(op2Sel, idRs2Value);
    end

    // rs2 still feeds the store data when the immediate is used
    assign opB = idUseImm ? idImm : rs2Fwd;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (idAluOp)
            cpuPkg::ALU_ADD: aluOut = rs1Fwd + opB;
            cpuPkg::ALU_SUB: aluOut = rs1Fwd - opB;
            cpuPkg::ALU_AND: aluOut = rs1Fwd & opB;
            cpuPkg::ALU_OR:  aluOut = rs1Fwd | opB;
            cpuPkg::ALU_XOR: aluOut = rs1Fwd ^ opB;
            default:         aluOut = opB;
        endcase
    end

    ////////////////////////////////////////
    // EX/MA register
    ////////////////////////////////////////

    // Bubble while the dependent instruction waits in ID/EX
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            maRegWe    <= 1'b0;
            maMemRead  <= 1'b0;
            maMemWrite <= 1'b0;
        end else begin
            maRegWe    <= idRegWe;
            maMemRead  <= idMemRead;
            maMemWrite <= idMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        maRs2       <= idRs2;
        maRd        <= idRd;
        maAluResult <= aluOut;
        maStoreData <= rs2Fwd;
    end

endmodule

// ==== design/memoryStage.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module memoryStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            maRegWe,
    input  logic            maMemRead,
    input  logic            maMemWrite,
    input  cpuPkg::regIndex maRd,
    input  cpuPkg::dataWord maAluResult,
    input  cpuPkg::dataWord maStoreData,
    input  logic            storeDataSel,
    output logic            wbEnable,
    output logic            wbIsLoad,
    output cpuPkg::regIndex wbRdst,
    output cpuPkg::dataWord wbData,
    output logic            vwbEnable,
    output cpuPkg::regIndex vwbRdst,
    output cpuPkg::dataWord vwbData,
    output logic            storeValid,
    output cpuPkg::memAddr  storeAddr,
    output cpuPkg::dataWord storeData
);

    cpuPkg::dataWord dmem [`CPU_DMEM_DEPTH];
    cpuPkg::memAddr  addr;

    assign addr = cpuPkg::memAddr'(maAluResult);

    // Loaded value arrives from write-back for a store right behind its load
    assign storeValid = maMemWrite;
    assign storeAddr  = addr;
    assign storeData  = storeDataSel ? wbData : maStoreData;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (maMemWrite) begin
            dmem[addr] <= storeData;
        end
    end

    ////////////////////////////////////////
    // MA/WB register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wbEnable <= 1'b0;
            wbIsLoad <= 1'b0;
        end else begin
            wbEnable <= maRegWe;
            wbIsLoad <= maMemRead;
        end
    end

    always_ff @(posedge clk) begin
        wbRdst <= maRd;
        wbData <= maMemRead ? dmem[addr] : maAluResult;
    end

    // Virtual write-back, one more cycle of the value just written,
    // because the register file has no write-through
    always_ff @(posedge clk) begin
        if (rst) begin
            vwbEnable <= 1'b0;
        end else begin
            vwbEnable <= wbEnable;
        end
    end

    always_ff @(posedge clk) begin
        vwbRdst <= wbRdst;
        vwbData <= wbData;
    end

endmodule

// ==== design/pipelineCpu.sv ====
`timescale 1ns/1ps

module pipelineCpu (
    input  logic             clk,
    input  logic             rst,
    input  logic             progWe,
    input  cpuPkg::memAddr   progAddr,
    input  cpuPkg::instrWord progData,
    output logic             wbValid,
    output cpuPkg::regIndex  wbRdst,
    output cpuPkg::dataWord  wbData,
    output logic             storeValid,
    output cpuPkg::memAddr   storeAddr,
    output cpuPkg::dataWord  storeData
);

    cpuPkg::instrWord ifInstr;
    logic             stall;

    // ID/EX
    logic            idRegWe, idMemRead, idMemWrite;
    logic            idRs1Needed, idRs2Needed, idUseImm;
    cpuPkg::regIndex idRs1, idRs2, idRd;
    cpuPkg::aluOp    idAluOp;
    cpuPkg::dataWord idRs1Value, idRs2Value, idImm;

    // EX/MA
    logic            maRegWe, maMemRead, maMemWrite;
    cpuPkg::regIndex maRs2, maRd;
    cpuPkg::dataWord maAluResult, maStoreData;

    // MA/WB and virtual write-back
    logic            wbEnable, wbIsLoad, vwbEnable;
    cpuPkg::regIndex vwbRdst;
    cpuPkg::dataWord vwbData;

    cpuPkg::fwdSel op1Sel, op2Sel;
    logic          storeDataSel;

    assign wbValid = wbEnable;

    fetchStage fetch (
        .clk, .rst, .progWe, .progAddr, .progData, .stall, .ifInstr
    );

    decodeStage decode (
        .clk, .rst, .stall, .ifInstr, .wbEnable, .wbRdst, .wbData,
        .idRegWe, .idMemRead, .idMemWrite, .idRs1Needed, .idRs2Needed, .idUseImm,
        .idRs1, .idRs2, .idRd, .idAluOp, .idRs1Value, .idRs2Value, .idImm
    );

    forwardUnit forward (
        .idRegWe, .idMemRead, .idMemWrite, .idRs1Needed, .idRs2Needed, .idRs1, .idRs2,
        .maRegWe, .maMemRead, .maMemWrite, .maRs2, .maRd,
        .wbEnable, .wbIsLoad, .wbRdst, .vwbEnable, .vwbRdst,
        .op1Sel, .op2Sel, .storeDataSel, .stall
    );

    executeStage execute (
        .clk, .rst, .stall,
        .idRegWe, .idMemRead, .idMemWrite, .idUseImm, .idRs2, .idRd, .idAluOp,
        .idRs1Value, .idRs2Value, .idImm, .op1Sel, .op2Sel,
        .maResult(maAluResult), .wbData, .vwbData,
        .maRegWe, .maMemRead, .maMemWrite, .maRs2, .maRd, .maAluResult, .maStoreData
    );

    memoryStage memory (
        .clk, .rst, .maRegWe, .maMemRead, .maMemWrite, .maRd, .maAluResult, .maStoreData,
        .storeDataSel, .wbEnable, .wbIsLoad, .wbRdst, .wbData,
        .vwbEnable, .vwbRdst, .vwbData, .storeValid, .storeAddr, .storeData
    );

endmodule

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuTb;

    logic             clk;
    logic             rst;
    logic             progWe;
    cpuPkg::memAddr   progAddr;
    cpuPkg::instrWord progData;
    logic             wbValid;
    cpuPkg::regIndex  wbRdst;
    cpuPkg::dataWord  wbData;
    logic             storeValid;
    cpuPkg::memAddr   storeAddr;
    cpuPkg::dataWord  storeData;

    cpuPkg::instrWord prog [$];
    cpuPkg::regIndex  expRd [$];
    cpuPkg::dataWord  expVal [$];
    cpuPkg::memAddr   expAddr [$];
    cpuPkg::dataWord  expData [$];

    int          errorCount = 0;
    int          passCount = 0;
    int          failCount = 0;
    longint      budgetCycles = 50;
    logic [31:0] rngState = 32'd75;

    pipelineCpu DUT (
        .clk, .rst, .progWe, .progAddr, .progData,
        .wbValid, .wbRdst, .wbData, .storeValid, .storeAddr, .storeData
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////

    function automatic cpuPkg::instrWord regOp(cpuPkg::opCode op, int rd, int rs1, int rs2);
        return {op, 5'(rd), 5'(rs1), 5'(rs2), 11'd0};
    endfunction

    function automatic cpuPkg::instrWord immOp(cpuPkg::opCode op, int rd, int rs1, int imm);
        return {op, 5'(rd), 5'(rs1), 16'(imm)};
    endfunction

    // Offset sits below the rs2 field
    function automatic cpuPkg::instrWord storeOp(int rs1, int rs2, int offset);
        return {cpuPkg::OP_SW, 5'd0, 5'(rs1), 5'(rs2), 11'(offset)};
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState;
    endfunction

    function automatic int randBelow(int n);
        logic [31:0] r;
        r = nextRandom();
        return int'(r[30:16]) % n;
    endfunction

    ////////////////////////////////////////
    // In-order ISA model
    ////////////////////////////////////////

    function automatic void modelProgram();
        cpuPkg::dataWord regs [`CPU_REG_COUNT];
        cpuPkg::dataWord mem [`CPU_DMEM_DEPTH];
        cpuPkg::dataWord a, b, imm, res;
        cpuPkg::regIndex rd;
        logic            writes;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
        foreach (prog[i]) begin
            rd     = prog[i][25:21];
            a      = regs[prog[i][20:16]];
            b      = regs[prog[i][15:11]];
            imm    = {{(`CPU_DATA_WIDTH-16){prog[i][15]}}, prog[i][15:0]};
            writes = 1'b1;
            res    = '0;
            case (cpuPkg::opCode'(prog[i][31:26]))
                cpuPkg::OP_ADD:  res = a + b;
                cpuPkg::OP_SUB:  res = a - b;
                cpuPkg::OP_AND:  res = a & b;
                cpuPkg::OP_OR:   res = a | b;
                cpuPkg::OP_XOR:  res = a ^ b;
                cpuPkg::OP_ADDI: res = a + imm;
                cpuPkg::OP_LW:   res = mem[cpuPkg::memAddr'(a + imm)];
                cpuPkg::OP_SW: begin
                    mem[cpuPkg::memAddr'(a + imm)] = b;
                    expAddr.push_back(cpuPkg::memAddr'(a + imm));
                    expData.push_back(b);
                    writes = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            // r0 keeps zero and never shows up as a write
            if (writes && rd != '0) begin
                regs[rd] = res;
                expRd.push_back(rd);
                expVal.push_back(res);
            end
        end
    endfunction

    ////////////////////////////////////////
    // Output checks, sampled mid-cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            quietInReset: assert (!wbValid && !storeValid) else begin
                $display("valid pulse seen at %0t while reset is high", $time);
                errorCount++;
            end
        end else begin
            if (wbValid) begin
                writeExpected: assert (expRd.size() > 0) else begin
                    $display("unexpected register write to r%0d at %0t", wbRdst, $time);
                    errorCount++;
                end
                if (expRd.size() > 0) begin
                    writeDest: assert (wbRdst == expRd[0]) else begin
                        $display("** Error at %0t: wbRdst expected %0d, got %0d",
                                 $time, expRd[0], wbRdst);
                        errorCount++;
                    end
                    writeValue: assert (wbData == expVal[0]) else begin
                        $display("** Error at %0t: wbData expected %h, got %h",
                                 $time, expVal[0], wbData);
                        errorCount++;
                    end
                    void'(expRd.pop_front());
                    void'(expVal.pop_front());
                end
            end
            if (storeValid) begin
                storeExpected: assert (expAddr.size() > 0) else begin
                    $display("unexpected store to address %0d at %0t", storeAddr, $time);
                    errorCount++;
                end
                if (expAddr.size() > 0) begin
                    storeAddrOk: assert (storeAddr == expAddr[0]) else begin
                        $display("** Error at %0t: storeAddr expected %0d, got %0d",
                                 $time, expAddr[0], storeAddr);
                        errorCount++;
                    end
                    storeDataOk: assert (storeData == expData[0]) else begin
                        $display("** Error at %0t: storeData expected %h, got %h",
                                 $time, expData[0], storeData);
                        errorCount++;
                    end
                    void'(expAddr.pop_front());
                    void'(expData.pop_front());
                end
            end
        end
    end

    // Loads the program under reset, runs it and drains the pipeline
    task automatic runTest(input string name);
        int errorsBefore;
        int waited;
        errorsBefore = errorCount;
        expRd.delete();
        expVal.delete();
        expAddr.delete();
        expData.delete();
        modelProgram();
        budgetCycles += prog.size() * 3 + 40;
        rst = 1'b1;
        foreach (prog[i]) begin
            progWe   = 1'b1;
            progAddr = cpuPkg::memAddr'(i);
            progData = prog[i];
            @(posedge clk);
            #1;
        end
        progWe = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        rst    = 1'b0;
        waited = 0;
        while ((expRd.size() + expAddr.size()) > 0 && waited < prog.size() * 2 + 20) begin
            @(posedge clk);
            #1;
            waited++;
        end
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        if ((expRd.size() + expAddr.size()) > 0) begin
            $display("%0d writes and %0d stores never appeared", expRd.size(), expAddr.size());
            errorCount++;
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: FAILED", name);
        end
    endtask

    task automatic randomProgram();
        int stored [$];
        int pick;
        int addr;
        prog.delete();
        // Seed r1 to r7 since the register file survives reset
        for (int r = 1; r < 8; r++) begin
            prog.push_back(immOp(cpuPkg::OP_ADDI, r, 0, randBelow(65536)));
        end
        for (int i = prog.size(); i < 40; i++) begin
            pick = randBelow(8);
            if (pick == 7 && stored.size() > 0) begin
                addr = stored[randBelow(stored.size())];
                prog.push_back(immOp(cpuPkg::OP_LW, randBelow(8), 0, addr));
            end else if (pick == 6) begin
                addr = randBelow(16);
                stored.push_back(addr);
                prog.push_back(storeOp(0, randBelow(8), addr));
            end else if (pick >= 5) begin
                prog.push_back(immOp(cpuPkg::OP_ADDI, randBelow(8), randBelow(8),
                                     randBelow(65536)));
            end else begin
                prog.push_back(regOp(cpuPkg::opCode'(pick + 1), randBelow(8), randBelow(8),
                                     randBelow(8)));
            end
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        @(posedge clk);
        #1;

        // Each result feeds the next instruction
        prog = '{immOp(cpuPkg::OP_ADDI, 1, 0, 5), regOp(cpuPkg::OP_ADD, 2, 1, 1),
                 regOp(cpuPkg::OP_SUB, 3, 2, 1), regOp(cpuPkg::OP_XOR, 4, 3, 2),
                 regOp(cpuPkg::OP_OR, 5, 4, 3), regOp(cpuPkg::OP_AND, 6, 5, 4),
                 immOp(cpuPkg::OP_ADDI, 7, 6, -3)};
        runTest("back-to-back");

        prog = '{immOp(cpuPkg::OP_ADDI, 1, 0, 7), immOp(cpuPkg::OP_ADDI, 2, 0, 11), '0,
                 regOp(cpuPkg::OP_ADD, 3, 1, 2), '0, '0, regOp(cpuPkg::OP_SUB, 4, 3, 1),
                 immOp(cpuPkg::OP_ADDI, 5, 0, 1), regOp(cpuPkg::OP_XOR, 6, 4, 5)};
        runTest("distance 2 and 3");

        // Load-use on rs1, then on rs2
        prog = '{immOp(cpuPkg::OP_ADDI, 1, 0, 100), immOp(cpuPkg::OP_ADDI, 2, 0, 9),
                 storeOp(0, 1, 20), immOp(cpuPkg::OP_LW, 3, 0, 20),
                 regOp(cpuPkg::OP_ADD, 4, 3, 2), immOp(cpuPkg::OP_LW, 5, 0, 20),
                 regOp(cpuPkg::OP_ADD, 6, 2, 5), regOp(cpuPkg::OP_SUB, 7, 6, 4),
                 immOp(cpuPkg::OP_ADDI, 8, 7, 1)};
        runTest("load-use");

        prog = '{immOp(cpuPkg::OP_ADDI, 1, 0, 77), storeOp(0, 1, 30),
                 immOp(cpuPkg::OP_LW, 2, 0, 30), storeOp(0, 2, 31),
                 immOp(cpuPkg::OP_ADDI, 3, 0, 40), storeOp(3, 1, 2),
                 immOp(cpuPkg::OP_LW, 4, 0, 31), regOp(cpuPkg::OP_ADD, 5, 4, 0)};
        runTest("load-store");

        prog = '{immOp(cpuPkg::OP_ADDI, 1, 0, 3), immOp(cpuPkg::OP_ADDI, 0, 0, 55),
                 regOp(cpuPkg::OP_ADD, 2, 0, 1), immOp(cpuPkg::OP_LW, 0, 0, 0),
                 regOp(cpuPkg::OP_ADD, 3, 0, 0)};
        runTest("r0 writes");

        for (int k = 0; k < 20; k++) begin
            randomProgram();
            runTest($sformatf("random %0d", k));
        end

        $display("%0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Budget grows as each test starts
    initial begin : watchdog
        longint cycles;
        cycles = 0;
        while (cycles < budgetCycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
design/cpuPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/forwardUnit.sv
design/executeStage.sv
design/memoryStage.sv
design/pipelineCpu.sv
test/cpuTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module cpuTb -Mdir obj_dir
	./obj_dir/VcpuTb | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
